/* Bender.yml */
package:
  name: ray_block_intersect

sources:
  - hdl/ray_pkg.sv
  - hdl/vec3_if.sv
  - hdl/slab_bounds.sv
  - hdl/slab_divider.sv
  - hdl/slab_interval.sv
  - hdl/ray_block_intersect.sv
  - target: test
    files:
      - bench/ray_block_intersect_assertions.sv
      - bench/ray_block_intersect_tb.sv

/* bench/ray_block_intersect_assertions.sv */
`timescale 1ns/1ps

module ray_block_intersect_assertions import ray_pkg::*; (
    input logic   clk_in,
    input logic   rst_in,
    input logic   valid_in,
    input logic   valid_out,
    input logic   intersects,
    input fixed_t t_out
);

    // clocks since reset, stops at the pipeline depth
    int settle;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            settle <= 0;
        end else if (settle < TOTAL_LATENCY) begin
            settle <= settle + 1;
        end
    end

    //////////////////////////////////////////////////

    valid_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        (settle >= TOTAL_LATENCY) |-> (valid_out == $past(valid_in, TOTAL_LATENCY)))
        else $error("valid_out does not follow valid_in by the pipeline latency");

    miss_zero: assert property (@(posedge clk_in) disable iff (rst_in)
        (valid_out && !intersects) |-> (t_out == '0))
        else $error("t_out is nonzero on a miss");

    reset_quiet: assert property (@(posedge clk_in)
        (rst_in && $past(rst_in)) |-> (!valid_out && !intersects))
        else $error("valid_out or intersects high during reset");

endmodule

bind ray_block_intersect ray_block_intersect_assertions u_assertions (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .valid_in   (valid_in),
    .valid_out  (valid_out),
    .intersects (intersects),
    .t_out      (t_out)
);

/* bench/ray_block_intersect_tb.sv */
`timescale 1ns/1ps

module ray_block_intersect_tb import ray_pkg::*; ();

    localparam int FIELDS        = 10;
    localparam int MAX_VECTORS   = 64;
    localparam int RESET_CYCLES  = 3;
    localparam int FLUSH_VECTORS = 4;
    localparam int FLUSH_WAIT    = TOTAL_LATENCY + 10;

    logic   clk_in;
    logic   rst_in;
    fixed_t ray_x, ray_y, ray_z;
    fixed_t block_x, block_y, block_z;
    logic   is_saber;
    logic   valid_in;
    logic   intersects;
    fixed_t t_out;
    logic   valid_out;

    logic [31:0] vec_mem [0:MAX_VECTORS*FIELDS-1];

    // scoreboard, one entry per issued vector
    int     name_q [$];
    logic   hit_q  [$];
    fixed_t t_q    [$];

    int n_vec         = 0;
    int pass_count    = 0;
    int fail_count    = 0;
    int stray_count   = 0;
    int cycle_count   = 0;
    int timeout_limit = 0;

    ray_block_intersect DUT (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .ray_x      (ray_x),
        .ray_y      (ray_y),
        .ray_z      (ray_z),
        .block_x    (block_x),
        .block_y    (block_y),
        .block_z    (block_z),
        .is_saber   (is_saber),
        .valid_in   (valid_in),
        .intersects (intersects),
        .t_out      (t_out),
        .valid_out  (valid_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    function automatic string test_name(input int idx);
        case (idx)
            0:       return "block_center_hit";
            1:       return "block_side_miss";
            2:       return "block_offset_z_hit";
            3:       return "saber_same_spot_miss";
            4:       return "saber_hit";
            5:       return "block_shifted_x_hit";
            6:       return "saber_shifted_x_miss";
            7:       return "saber_edge_touch";
            8:       return "zero_xy_hit";
            9:       return "zero_xy_miss";
            10:      return "zero_x_hit";
            11:      return "ray_scale_two_hit";
            12:      return "behind_eye_hit";
            default: return $sformatf("vector_%0d", idx);
        endcase
    endfunction

    // first line whose name field is unknown ends the table
    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VECTORS && !$isunknown(vec_mem[n * FIELDS])) begin
            n++;
        end
        return n;
    endfunction

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("%-22s %s", name, ok ? "ok" : "FAILED");
    endtask

    task automatic apply_vector(input int idx, input bit expect_result);
        int base;
        base     = idx * FIELDS;
        ray_x    = vec_mem[base + 1];
        ray_y    = vec_mem[base + 2];
        ray_z    = vec_mem[base + 3];
        block_x  = vec_mem[base + 4];
        block_y  = vec_mem[base + 5];
        block_z  = vec_mem[base + 6];
        is_saber = vec_mem[base + 7][0];
        valid_in = 1'b1;
        if (expect_result) begin
            name_q.push_back(int'(vec_mem[base]));
            hit_q.push_back(vec_mem[base + 8][0]);
            t_q.push_back(vec_mem[base + 9]);
        end
        @(negedge clk_in);
    endtask

    //////////////////////////////////////////////////
    // result checker, outputs are settled mid-cycle

    always @(negedge clk_in) begin
        int     idx;
        logic   exp_hit;
        fixed_t exp_t;
        bit     ok;
        if (!rst_in && valid_out) begin
            if (name_q.size() == 0) begin
                $display("valid_out went high with no vector pending");
                stray_count++;
                fail_count++;
            end else begin
                idx     = name_q.pop_front();
                exp_hit = hit_q.pop_front();
                exp_t   = t_q.pop_front();
                ok      = 1'b1;
                if (intersects !== exp_hit) begin
                    $display("Mismatch %s intersects expected %0b actual %0b",
                             test_name(idx), exp_hit, intersects);
                    ok = 1'b0;
                end
                if (t_out !== exp_t) begin
                    $display("Mismatch %s t_out expected %08h actual %08h",
                             test_name(idx), exp_t, t_out);
                    ok = 1'b0;
                end
                report_test(test_name(idx), ok);
            end
        end
    end

    always @(posedge clk_in) begin
        cycle_count++;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, %0d expected results never came out",
                     cycle_count, name_q.size());
            $display("Some tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus

    initial begin
        int before_flush;
        rst_in   = 1'b1;
        valid_in = 1'b0;
        ray_x    = '0;
        ray_y    = '0;
        ray_z    = '0;
        block_x  = '0;
        block_y  = '0;
        block_z  = '0;
        is_saber = 1'b0;

        $readmemh("bench/ray_block_testdata.txt", vec_mem);
        n_vec = count_vectors();
        timeout_limit = 2 * RESET_CYCLES + n_vec + TOTAL_LATENCY + 20
                        + FLUSH_VECTORS + FLUSH_WAIT;

        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_in = 1'b0;

        if (n_vec == 0) begin
            $display("No test vectors could be read from the data file");
            fail_count++;
        end else begin
            // whole table back to back
            for (int i = 0; i < n_vec; i++) begin
                apply_vector(i, 1'b1);
            end
            valid_in = 1'b0;
            while (name_q.size() != 0) begin
                @(negedge clk_in);
            end

            // reset while samples are still in flight
            before_flush = stray_count;
            for (int i = 0; i < FLUSH_VECTORS && i < n_vec; i++) begin
                apply_vector(i, 1'b0);
            end
            valid_in = 1'b0;
            rst_in   = 1'b1;
            repeat (RESET_CYCLES) @(negedge clk_in);
            rst_in = 1'b0;
            repeat (FLUSH_WAIT) @(negedge clk_in);
            report_test("reset_flush", stray_count == before_flush);
        end

        $display("Results: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* bench/ray_block_testdata.txt */
// name ray_x ray_y ray_z block_x block_y block_z is_saber exp_intersects exp_t_out
// all fields hex, rays and positions in Q16.16, eye at (1800, 1800, -300)
// ray (-1,-1,1) against blocks and sabers
00 FFFF0000 FFFF0000 00010000 03200000 03200000 02BC0000 0 1 03840007
01 FFFF0000 FFFF0000 00010000 044C0000 03200000 02BC0000 0 0 00000000
02 FFFF0000 FFFF0000 00010000 03200000 03200000 02D00000 0 1 03980007
03 FFFF0000 FFFF0000 00010000 03200000 03200000 02D00000 1 0 00000000
04 FFFF0000 FFFF0000 00010000 03200000 03200000 028A0000 1 1 03E30007
05 FFFF0000 FFFF0000 00010000 03340000 03200000 028A0000 0 1 03840007
06 FFFF0000 FFFF0000 00010000 03340000 03200000 028A0000 1 0 00000000
// tmin equals tmax
07 FFFF0000 FFFF0000 00010000 032A0000 03200000 028A0000 1 1 03E30007
// zero ray components, divider saturates
08 00000000 00000000 00010000 07080000 07080000 01F40000 0 1 02BC0007
09 00000000 00000000 00010000 07D00000 07080000 01F40000 0 0 00000000
0A 00000000 FFFF0000 00010000 07080000 03200000 02BC0000 0 1 03840007
// quotient truncation with a ray of length two
0B FFFE0000 FFFE0000 00020000 03200000 03200000 02BC0000 0 1 01C20003
// box behind the eye gives a negative entry
0C 00010000 00010000 FFFF0000 03200000 03200000 02BC0000 0 1 FBB3FFF9

/* hdl/ray_block_intersect.sv */
`timescale 1ns/1ps

module ray_block_intersect import ray_pkg::*; (
    input  logic   clk_in,
    input  logic   rst_in,

    input  fixed_t ray_x,
    input  fixed_t ray_y,
    input  fixed_t ray_z,
    input  fixed_t block_x,
    input  fixed_t block_y,
    input  fixed_t block_z,
    input  logic   is_saber,
    input  logic   valid_in,

    output logic   intersects,
    output fixed_t t_out,
    output logic   valid_out
);

    vec3_if corner_min ();
    vec3_if corner_max ();
    vec3_if t1 ();
    vec3_if t2 ();

    fixed_t ray_x_d [BOUNDS_LATENCY];
    fixed_t ray_y_d [BOUNDS_LATENCY];
    fixed_t ray_z_d [BOUNDS_LATENCY];

    //////////////////////////////////////////////////
    // ray delay, lines up with the corners

    always_ff @(posedge clk_in) begin
        ray_x_d[0] <= ray_x;
        ray_y_d[0] <= ray_y;
        ray_z_d[0] <= ray_z;
        for (int i = 1; i < BOUNDS_LATENCY; i++) begin
            ray_x_d[i] <= ray_x_d[i-1];
            ray_y_d[i] <= ray_y_d[i-1];
            ray_z_d[i] <= ray_z_d[i-1];
        end
    end

    //////////////////////////////////////////////////
    // stages

    slab_bounds u_bounds (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .block_x    (block_x),
        .block_y    (block_y),
        .block_z    (block_z),
        .is_saber   (is_saber),
        .valid_in   (valid_in),
        .corner_min (corner_min),
        .corner_max (corner_max)
    );

    // t1 from the min corner
    slab_divider u_div_min (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .numer  (corner_min),
        .ray_x  (ray_x_d[BOUNDS_LATENCY-1]),
        .ray_y  (ray_y_d[BOUNDS_LATENCY-1]),
        .ray_z  (ray_z_d[BOUNDS_LATENCY-1]),
        .quot   (t1)
    );

    // t2 from the max corner
    slab_divider u_div_max (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .numer  (corner_max),
        .ray_x  (ray_x_d[BOUNDS_LATENCY-1]),
        .ray_y  (ray_y_d[BOUNDS_LATENCY-1]),
        .ray_z  (ray_z_d[BOUNDS_LATENCY-1]),
        .quot   (t2)
    );

    slab_interval u_interval (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .t1         (t1),
        .t2         (t2),
        .intersects (intersects),
        .t_out      (t_out),
        .valid_out  (valid_out)
    );

endmodule

/* hdl/ray_pkg.sv */
package ray_pkg;

    // signed Q16.16
    typedef logic signed [31:0] fixed_t;

    //////////////////////////////////////////////////
    // shape sizes

    localparam fixed_t BLOCK_HALF   = 32'sh0064_0000;
    localparam fixed_t SABER_HALF   = 32'sh0005_0000;
    localparam fixed_t SABER_LENGTH = 32'sh0096_0000;

    // eye point, nudged by one small lsb step off the grid
    localparam fixed_t EYE_X = 32'sh0708_0007;
    localparam fixed_t EYE_Y = 32'sh0708_0007;
    // -300 minus the offset
    localparam fixed_t EYE_Z = 32'shFED3_FFF9;

    // divider saturation
    localparam fixed_t FIXED_MAX = 32'sh7FFF_FFFF;
    localparam fixed_t FIXED_MIN = 32'sh8000_0000;

    //////////////////////////////////////////////////
    // stage latencies in clocks

    localparam int BOUNDS_LATENCY   = 2;
    localparam int DIV_LATENCY      = 34;
    localparam int INTERVAL_LATENCY = 3;
    localparam int TOTAL_LATENCY    = BOUNDS_LATENCY + DIV_LATENCY + INTERVAL_LATENCY;

endpackage

/* hdl/slab_bounds.sv */
`timescale 1ns/1ps

module slab_bounds import ray_pkg::*; (
    input  logic   clk_in,
    input  logic   rst_in,

    input  fixed_t block_x,
    input  fixed_t block_y,
    input  fixed_t block_z,
    input  logic   is_saber,
    input  logic   valid_in,

    vec3_if.src    corner_min,
    vec3_if.src    corner_max
);

    fixed_t half_xy;
    fixed_t min_x, min_y, min_z;
    fixed_t max_x, max_y, max_z;
    logic   box_valid;

    // saber is thin in x/y
    assign half_xy = is_saber ? SABER_HALF : BLOCK_HALF;

    //////////////////////////////////////////////////
    // cycle 1: box extent around the position

    always_ff @(posedge clk_in) begin
        min_x <= block_x - half_xy;
        min_y <= block_y - half_xy;
        max_x <= block_x + half_xy;
        max_y <= block_y + half_xy;
        // saber starts at its position and runs along +z
        min_z <= is_saber ? block_z : block_z - BLOCK_HALF;
        max_z <= block_z + (is_saber ? SABER_LENGTH : BLOCK_HALF);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            box_valid <= 1'b0;
        end else begin
            box_valid <= valid_in;
        end
    end

    //////////////////////////////////////////////////
    // cycle 2: corners relative to the eye

    always_ff @(posedge clk_in) begin
        corner_min.x <= min_x - EYE_X;
        corner_min.y <= min_y - EYE_Y;
        corner_min.z <= min_z - EYE_Z;
        corner_max.x <= max_x - EYE_X;
        corner_max.y <= max_y - EYE_Y;
        corner_max.z <= max_z - EYE_Z;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            corner_min.valid <= 1'b0;
            corner_max.valid <= 1'b0;
        end else begin
            corner_min.valid <= box_valid;
            corner_max.valid <= box_valid;
        end
    end

endmodule

/* hdl/slab_divider.sv */
`timescale 1ns/1ps

module slab_divider import ray_pkg::*; (
    input  logic   clk_in,
    input  logic   rst_in,

    vec3_if.dst    numer,
    input  fixed_t ray_x,
    input  fixed_t ray_y,
    input  fixed_t ray_z,

    vec3_if.src    quot
);

    fixed_t numer_in [3];
    fixed_t denom_in [3];
    fixed_t quot_out [3];
    logic [DIV_LATENCY-1:0] valid_pipe;

    assign numer_in[0] = numer.x;
    assign numer_in[1] = numer.y;
    assign numer_in[2] = numer.z;
    assign denom_in[0] = ray_x;
    assign denom_in[1] = ray_y;
    assign denom_in[2] = ray_z;

    assign quot.x     = quot_out[0];
    assign quot.y     = quot_out[1];
    assign quot.z     = quot_out[2];
    assign quot.valid = valid_pipe[DIV_LATENCY-1];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[DIV_LATENCY-2:0], numer.valid};
        end
    end

    for (genvar a = 0; a < 3; a++) begin : g_axis
        logic [31:0] n_abs;
        logic [31:0] d_abs;
        logic [31:0] num_mag [0:31];
        logic [31:0] den_mag [0:31];
        logic [31:0] rem     [0:31];
        logic [31:0] q       [1:32];
        logic        sat     [0:32];
        logic        neg     [0:32];

        assign n_abs = numer_in[a][31] ? -numer_in[a] : numer_in[a];
        assign d_abs = denom_in[a][31] ? -denom_in[a] : denom_in[a];

        // input register with magnitudes, signs and overflow check
        always_ff @(posedge clk_in) begin
            num_mag[0] <= n_abs;
            den_mag[0] <= d_abs;
            rem[0]     <= {16'h0000, n_abs[31:16]};
            // also true for a zero divisor
            sat[0]     <= {16'h0000, n_abs[31:16]} >= d_abs;
            // a zero divisor has a clear sign bit and keeps the numerator sign
            neg[0]     <= numer_in[a][31] ^ denom_in[a][31];
        end

        // one quotient bit per stage from the msb down
        for (genvar s = 1; s <= 32; s++) begin : g_stage
            localparam int BIT = 32 - s;
            logic [47:0] dvd;
            logic [32:0] shifted;
            logic        take;

            assign dvd     = {num_mag[s-1], 16'h0000};
            assign shifted = {rem[s-1], dvd[BIT]};
            assign take    = shifted >= {1'b0, den_mag[s-1]};

            always_ff @(posedge clk_in) begin
                sat[s] <= sat[s-1];
                neg[s] <= neg[s-1];
            end

            if (s == 1) begin : g_first
                always_ff @(posedge clk_in) begin
                    q[s] <= {31'h0, take};
                end
            end else begin : g_next
                always_ff @(posedge clk_in) begin
                    q[s] <= {q[s-1][30:0], take};
                end
            end

            if (s < 32) begin : g_carry
                logic [32:0] diff;

                assign diff = shifted - {1'b0, den_mag[s-1]};

                always_ff @(posedge clk_in) begin
                    rem[s]     <= take ? diff[31:0] : shifted[31:0];
                    num_mag[s] <= num_mag[s-1];
                    den_mag[s] <= den_mag[s-1];
                end
            end
        end

        // sign and saturate
        always_ff @(posedge clk_in) begin
            if (sat[32] || q[32][31]) begin
                quot_out[a] <= neg[32] ? FIXED_MIN : FIXED_MAX;
            end else begin
                quot_out[a] <= neg[32] ? -fixed_t'(q[32]) : fixed_t'(q[32]);
            end
        end
    end

endmodule

/* hdl/slab_interval.sv */
`timescale 1ns/1ps

module slab_interval import ray_pkg::*; (
    input  logic   clk_in,
    input  logic   rst_in,

    vec3_if.dst    t1,
    vec3_if.dst    t2,

    output logic   intersects,
    output fixed_t t_out,
    output logic   valid_out
);

    fixed_t near_x, near_y, near_z;
    fixed_t far_x, far_y, far_z;
    logic   near_valid;

    fixed_t tmin, tmax;
    logic   reduce_valid;
    logic   hit;

    function automatic fixed_t fmin(input fixed_t a, input fixed_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic fixed_t fmax(input fixed_t a, input fixed_t b);
        return (a > b) ? a : b;
    endfunction

    //////////////////////////////////////////////////
    // cycle 1: near and far per axis

    always_ff @(posedge clk_in) begin
        near_x <= fmin(t1.x, t2.x);
        near_y <= fmin(t1.y, t2.y);
        near_z <= fmin(t1.z, t2.z);
        far_x  <= fmax(t1.x, t2.x);
        far_y  <= fmax(t1.y, t2.y);
        far_z  <= fmax(t1.z, t2.z);
    end

    //////////////////////////////////////////////////
    // cycle 2: latest entry, earliest exit

    always_ff @(posedge clk_in) begin
        tmin <= fmax(near_x, fmax(near_y, near_z));
        tmax <= fmin(far_x, fmin(far_y, far_z));
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            near_valid   <= 1'b0;
            reduce_valid <= 1'b0;
        end else begin
            // t2 valid runs in step with t1
            near_valid   <= t1.valid;
            reduce_valid <= near_valid;
        end
    end

    //////////////////////////////////////////////////
    // cycle 3: hit test

    assign hit = reduce_valid && (tmin <= tmax);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            intersects <= 1'b0;
            t_out      <= '0;
            valid_out  <= 1'b0;
        end else begin
            intersects <= hit;
            // zero on a miss
            t_out      <= hit ? tmin : '0;
            valid_out  <= reduce_valid;
        end
    end

endmodule

/* hdl/vec3_if.sv */
`timescale 1ns/1ps

interface vec3_if import ray_pkg::*; ();

    fixed_t x;
    fixed_t y;
    fixed_t z;
    logic   valid;

    // producer side
    modport src (output x, output y, output z, output valid);

    // consumer side
    modport dst (input x, input y, input z, input valid);

endinterface

/* ray_block_intersect.f */
hdl/ray_pkg.sv
hdl/vec3_if.sv
hdl/slab_bounds.sv
hdl/slab_divider.sv
hdl/slab_interval.sv
hdl/ray_block_intersect.sv
bench/ray_block_intersect_assertions.sv
bench/ray_block_intersect_tb.sv
